// ==== i2c_reg_slave.f ====
verilog/i2c_bus_pkg.sv
verilog/slave_regs_pkg.sv
verilog/i2c_if.sv
verilog/bus_sampler.sv
verilog/transaction_fsm.sv
verilog/reg_file.sv
verilog/sda_driver.sv
verilog/i2c_reg_slave.sv
tests/i2c_reg_slave_chk.sv
tests/i2c_reg_slave_tb.sv

// ==== Makefile ====
TB_TOP = i2c_reg_slave_tb

all: run

build:
	verilator --binary --timing --top-module $(TB_TOP) -f i2c_reg_slave.f -o $(TB_TOP)

run: build
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -qx "Regression passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module i2c_reg_slave -f i2c_reg_slave.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== tests/i2c_reg_slave_tests.txt ====
# op dev reg count bytes; op is W, R, WR or CHK_NACK; dev and reg hex, count decimal
# W bytes are hex or RND (random, kept in the model); R and WR bytes are hex or M (model)
CHK_NACK 37 0000 0
CHK_NACK 1b 0000 0
W 36 0005 4 RND RND RND RND
WR 36 0005 4 M M M M
R 36 0000 17 36 A0 A1 A2 A3 M M M M B4 B5 B6 B7 FF FF FF FF
W 36 0001 4 11 22 33 44
W 36 1234 2 55 66
R 36 0001 4 A0 A1 A2 A3
R 36 1234 2 FF FF
W 36 000B 3 C1 C2 RND
WR 36 0009 6 B4 B5 C1 C2 FF FF
W 36 0000 1 50
CHK_NACK 36 0000 0
WR 50 0000 2 50 A0
R 50 0005 8 M M M M B4 B5 C1 C2
W 50 0000 1 36
CHK_NACK 50 0000 0
WR 36 0000 1 36

// ==== tests/i2c_reg_slave_tb.sv ====
`timescale 1ns/1ns

module i2c_reg_slave_tb;

	localparam int CLK_HALF = 50;
	localparam int SCL_LEVEL = 10; // sys_clk cycles per scl level
	localparam int CYCLES_PER_OP = 40 * 9 * 2 * SCL_LEVEL; // 40 bytes of 9 bits

	logic sys_clk;
	logic rst_n;
	logic scl;
	logic sda_m; // master drive level
	logic sda_oe;
	logic sda;
	int errors;
	int checks;
	int op_count;
	int fd;
	logic limit_ready;
	logic [31:0] lcg_state;
	logic [7:0] rw_model [8]; // expected read-write bytes

	assign sda = sda_m & ~sda_oe; // open drain

	i2c_reg_slave dut0 (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.scl_i    (scl),
		.sda_i    (sda),
		.sda_oe_o (sda_oe)
	);

	initial begin
		sys_clk = 1'b0;
		forever #CLK_HALF sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic expect_ack(input logic acked, input string what);
		checks++;
		if (!acked) begin
			errors++;
			$display("the slave did not acknowledge the %s at %0t ns", what, $time);
		end
	endtask

	// scl low on entry and on exit, sda moves 2 cycles into the low level
	task automatic clock_bit(input logic b, output logic r);
		wait_cycles(2);
		sda_m = b;
		wait_cycles(SCL_LEVEL - 2);
		scl = 1'b1;
		wait_cycles(SCL_LEVEL / 2);
		r = sda;
		wait_cycles(SCL_LEVEL / 2);
		scl = 1'b0;
	endtask

	task automatic send_start();
		wait_cycles(2);
		sda_m = 1'b1;
		wait_cycles(SCL_LEVEL - 2);
		scl = 1'b1;
		wait_cycles(SCL_LEVEL);
		sda_m = 1'b0;
		wait_cycles(SCL_LEVEL);
		scl = 1'b0;
	endtask

	task automatic send_stop();
		wait_cycles(2);
		sda_m = 1'b0;
		wait_cycles(SCL_LEVEL - 2);
		scl = 1'b1;
		wait_cycles(SCL_LEVEL);
		sda_m = 1'b1;
		wait_cycles(SCL_LEVEL);
	endtask

	task automatic write_byte(input logic [7:0] b, output logic acked);
		logic r;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(b[i], r);
		end
		clock_bit(1'b1, r); // release for the slave's ack
		acked = !r;
	endtask

	task automatic read_byte(input logic ack, output logic [7:0] b);
		logic r;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, r);
			b[i] = r;
		end
		clock_bit(!ack, r);
	endtask

	task automatic run_op(input string op, input logic [6:0] dev, input logic [15:0] addr,
			input int count);
		string tok;
		logic [7:0] val;
		logic [7:0] got;
		logic [15:0] a;
		logic acked;
		int code;
		send_start();
		write_byte({dev, 1'b0}, acked);
		if (op == "CHK_NACK") begin
			check_value({7'd0, acked}, 8'd0, "ack for a foreign address");
			write_byte(8'h00, acked); // must stay silent
			check_value({7'd0, acked}, 8'd0, "ack while ignoring");
			send_stop();
			return;
		end
		expect_ack(acked, "write address byte");
		write_byte(addr[15:8], acked);
		expect_ack(acked, "register address high byte");
		write_byte(addr[7:0], acked);
		expect_ack(acked, "register address low byte");
		if (op == "W") begin
			for (int i = 0; i < count; i++) begin
				a = addr + 16'(i);
				code = $fscanf(fd, "%s", tok);
				if (tok == "RND") begin
					lcg_state = lcg_next(lcg_state);
					val = lcg_state[23:16];
				end else begin
					code = $sscanf(tok, "%h", val);
				end
				if (a >= 16'h0005 && a < 16'h000D) rw_model[a[2:0] - 3'd5] = val;
				write_byte(val, acked);
				expect_ack(acked, "write data byte");
			end
			send_stop();
			return;
		end
		if (op == "R") send_stop(); // register pointer must survive a stop
		send_start();
		write_byte({dev, 1'b1}, acked);
		expect_ack(acked, "read address byte");
		for (int i = 0; i < count; i++) begin
			a = addr + 16'(i);
			read_byte(i != count - 1, got); // nack the last byte
			code = $fscanf(fd, "%s", tok);
			if (tok == "M") val = rw_model[a[2:0] - 3'd5];
			else code = $sscanf(tok, "%h", val);
			check_value(got, val, $sformatf("read of register %h", a));
		end
		send_stop();
	endtask

	initial begin
		string tok;
		string line;
		logic [6:0] dev;
		logic [15:0] addr;
		int count;
		int code;
		errors = 0;
		checks = 0;
		op_count = 0;
		limit_ready = 1'b0;
		lcg_state = 32'h02e857c3;
		scl = 1'b1;
		sda_m = 1'b1;
		rst_n = 1'b0;
		for (int i = 0; i < 8; i++) rw_model[i] = 8'hB0 + 8'(i);
		fd = $fopen("tests/i2c_reg_slave_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/i2c_reg_slave_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") op_count++;
			end
			$fclose(fd);
			limit_ready = 1'b1;
			fd = $fopen("tests/i2c_reg_slave_tests.txt", "r");
			wait_cycles(4);
			rst_n = 1'b1;
			wait_cycles(4);
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok[0] == "#") begin
					code = $fgets(line, fd); // skip the comment
				end else begin
					code = $fscanf(fd, "%h %h %d", dev, addr, count);
					run_op(tok, dev, addr, count);
				end
			end
			$fclose(fd);
			wait_cycles(20);
		end
		errors += dut0.chk0.fail_count; // failed assertions of the bound checker
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (limit_ready);
		repeat (op_count * CYCLES_PER_OP) @(posedge sys_clk);
		$display("timeout, the tests did not finish in %0d operations' time", op_count);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== tests/i2c_reg_slave_chk.sv ====
`timescale 1ns/1ns

module i2c_reg_slave_chk (
	input logic sys_clk,
	input logic rst_n,
	input logic sda_oe_i,
	input logic scl_sync_i,
	input logic wr_en_i,
	input logic rd_en_i
);

	int fail_count = 0; // failed assertions so far

	// released in reset and in the first cycle after it
	reset_release: assert property (@(posedge sys_clk) !rst_n |=> !sda_oe_i)
		else begin
			$error("sda_oe_o active during or right after reset");
			fail_count++;
		end

	// data may only move while scl is low
	oe_stable_scl_high: assert property (@(posedge sys_clk) disable iff (!rst_n)
		scl_sync_i |-> $stable(sda_oe_i))
		else begin
			$error("sda_oe_o changed while scl was high");
			fail_count++;
		end

	no_wr_rd_overlap: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(wr_en_i && rd_en_i))
		else begin
			$error("wr_en and rd_en high together");
			fail_count++;
		end

endmodule

bind i2c_reg_slave i2c_reg_slave_chk chk0 (
	.sys_clk    (sys_clk),
	.rst_n      (rst_n),
	.sda_oe_i   (sda_oe_o),
	.scl_sync_i (u_sampler.scl_s),
	.wr_en_i    (reg_acc.wr_en),
	.rd_en_i    (reg_acc.rd_en)
);

// ==== verilog/i2c_reg_slave.sv ====
`timescale 1ns/1ns

module i2c_reg_slave
	import i2c_bus_pkg::*;
	import slave_regs_pkg::*;
#(
	parameter dev_addr_t RESET_DEV_ADDR = 7'h36
) (
	input logic sys_clk,
	input logic rst_n,
	input logic scl_i,
	input logic sda_i,
	output logic sda_oe_o // high pulls sda low
);

	bus_event_if bus_ev ();
	reg_access_if reg_acc ();

	phase_t phase;
	bit_cnt_t bit_cnt;
	logic ack_en;
	reg_data_t rd_byte;

	bus_sampler u_sampler (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.scl_i   (scl_i),
		.sda_i   (sda_i),
		.ev_o    (bus_ev.src)
	);

	transaction_fsm u_fsm (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.ev_i      (bus_ev.dst),
		.reg_o     (reg_acc.ctrl),
		.phase_o   (phase),
		.bit_cnt_o (bit_cnt),
		.ack_en_o  (ack_en),
		.rd_byte_o (rd_byte)
	);

	reg_file #(
		.RESET_DEV_ADDR (RESET_DEV_ADDR)
	) u_regs (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.reg_i   (reg_acc.regs)
	);

	sda_driver u_driver (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.ev_i      (bus_ev.dst),
		.phase_i   (phase),
		.bit_cnt_i (bit_cnt),
		.ack_en_i  (ack_en),
		.rd_byte_i (rd_byte),
		.sda_oe_o  (sda_oe_o)
	);

endmodule

// ==== verilog/sda_driver.sv ====
`timescale 1ns/1ns

module sda_driver
	import i2c_bus_pkg::*;
	import slave_regs_pkg::*;
(
	input logic sys_clk,
	input logic rst_n,
	bus_event_if.dst ev_i,
	input phase_t phase_i,
	input bit_cnt_t bit_cnt_i,
	input logic ack_en_i,
	input reg_data_t rd_byte_i,
	output logic sda_oe_o
);

	localparam bit_cnt_t ACK_BIT = bit_cnt_t'(BITS_PER_BYTE);

	bit_cnt_t next_bit; // bit that the coming scl_fall opens
	logic oe_next;

	assign next_bit = (bit_cnt_i == ACK_BIT) ? '0 : bit_cnt_i + 1'b1;

	always_comb begin
		oe_next = 1'b0; // released unless something pulls
		if (next_bit == ACK_BIT) begin
			// ack_en is low in reads, so the master's ack bit stays free
			oe_next = ack_en_i;
		end else if (phase_i == READ_DATA) begin
			oe_next = !rd_byte_i[3'd7 - next_bit[2:0]]; // pull for a 0
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			sda_oe_o <= 1'b0;
		end else if (ev_i.start || ev_i.stop) begin
			sda_oe_o <= 1'b0;
		end else if (ev_i.scl_fall) begin
			sda_oe_o <= oe_next; // only ever moves while scl is low
		end
	end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import slave_regs_pkg::*; #(
	parameter dev_addr_t RESET_DEV_ADDR = 7'h36
) (
	input logic sys_clk,
	input logic rst_n,
	reg_access_if.regs reg_i
);

	localparam int ID_IDX_W = $clog2(ID_COUNT);
	localparam int RW_IDX_W = $clog2(RW_COUNT);

	dev_addr_t dev_addr;
	reg_data_t rw_regs [RW_COUNT];
	reg_addr_t id_off;
	reg_addr_t rw_off;
	logic in_id;
	logic in_rw;

	// below the base the offset wraps high, so one compare is enough
	assign id_off = reg_i.addr - ID_BASE;
	assign rw_off = reg_i.addr - RW_BASE;
	assign in_id = id_off < reg_addr_t'(ID_COUNT);
	assign in_rw = rw_off < reg_addr_t'(RW_COUNT);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dev_addr <= RESET_DEV_ADDR;
			rw_regs <= RW_RESET_VALUES;
		end else if (reg_i.wr_en) begin
			if (reg_i.addr == DEV_ADDR_REG) begin
				dev_addr <= reg_i.wdata[6:0]; // used from the next address byte
			end else if (in_rw) begin
				rw_regs[rw_off[RW_IDX_W-1:0]] <= reg_i.wdata;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reg_i.rd_en) begin
			if (reg_i.addr == DEV_ADDR_REG) begin
				reg_i.rdata <= {1'b0, dev_addr};
			end else if (in_id) begin
				reg_i.rdata <= ID_VALUES[id_off[ID_IDX_W-1:0]];
			end else if (in_rw) begin
				reg_i.rdata <= rw_regs[rw_off[RW_IDX_W-1:0]];
			end else begin
				reg_i.rdata <= UNMAPPED_DATA;
			end
		end
	end

	assign reg_i.dev_addr = dev_addr;

endmodule

// ==== verilog/transaction_fsm.sv ====
`timescale 1ns/1ns

module transaction_fsm
	import i2c_bus_pkg::*;
	import slave_regs_pkg::*;
(
	input logic sys_clk,
	input logic rst_n,
	bus_event_if.dst ev_i,
	reg_access_if.ctrl reg_o,
	output phase_t phase_o,
	output bit_cnt_t bit_cnt_o,
	output logic ack_en_o,
	output reg_data_t rd_byte_o
);

	localparam bit_cnt_t ACK_BIT = bit_cnt_t'(BITS_PER_BYTE);
	localparam bit_cnt_t LAST_BIT = bit_cnt_t'(BITS_PER_BYTE - 1);

	phase_t phase;
	bit_cnt_t bit_cnt;
	reg_data_t shreg;
	reg_addr_t cur_addr;
	logic adv_pend; // data byte done, address moves at ack end
	logic rd_pend; // rdata lands this cycle
	logic byte_end;
	logic ack_end;
	logic addr_match;
	logic master_ack_bit;
	logic rd_first;
	logic rd_next;
	logic master_nack;

	assign byte_end = ev_i.scl_fall && bit_cnt == LAST_BIT; // opens the ack bit
	assign ack_end = ev_i.scl_fall && bit_cnt == ACK_BIT;
	assign addr_match = shreg[7:1] == reg_o.dev_addr;

	// ninth rise of a read byte, the master answers here
	assign master_ack_bit = ev_i.scl_rise && phase == READ_DATA && bit_cnt == ACK_BIT && adv_pend;
	assign rd_first = byte_end && phase == DEV_ADDR && addr_match && shreg[0];
	assign rd_next = master_ack_bit && !ev_i.sda_bit; // prefetch the next byte
	assign master_nack = master_ack_bit && ev_i.sda_bit;

	assign reg_o.wr_en = byte_end && phase == WRITE_DATA;
	assign reg_o.rd_en = rd_first || rd_next;
	assign reg_o.addr = rd_next ? cur_addr + 1'b1 : cur_addr;
	assign reg_o.wdata = shreg;

	always_comb begin
		case (phase)
			DEV_ADDR: ack_en_o = addr_match;
			REG_ADDR_HI, REG_ADDR_LO, WRITE_DATA: ack_en_o = 1'b1;
			default: ack_en_o = 1'b0; // reads are acked by the master
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			phase <= IDLE;
			bit_cnt <= ACK_BIT;
			cur_addr <= DEV_ADDR_REG;
			adv_pend <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= reg_o.rd_en;
			if (ev_i.stop) begin
				phase <= IDLE;
				adv_pend <= 1'b0;
			end else if (ev_i.start) begin
				phase <= DEV_ADDR;
				bit_cnt <= ACK_BIT; // start's own scl fall opens bit 0
				adv_pend <= 1'b0;
			end else if (phase != IDLE) begin
				if (ev_i.scl_fall) begin
					bit_cnt <= (bit_cnt == ACK_BIT) ? '0 : bit_cnt + 1'b1;
				end
				if (byte_end) begin
					adv_pend <= phase == WRITE_DATA || phase == READ_DATA;
					case (phase)
						DEV_ADDR: begin
							if (!addr_match) begin
								phase <= IGNORE; // not ours, stay off the bus
							end else if (shreg[0]) begin
								phase <= READ_DATA;
							end else begin
								phase <= REG_ADDR_HI;
							end
						end
						REG_ADDR_HI: begin
							cur_addr[15:8] <= shreg;
							phase <= REG_ADDR_LO;
						end
						REG_ADDR_LO: begin
							cur_addr[7:0] <= shreg;
							phase <= WRITE_DATA;
						end
						default: phase <= phase;
					endcase
				end
				if (ack_end && adv_pend) begin
					cur_addr <= cur_addr + 1'b1; // auto-increment
					adv_pend <= 1'b0;
				end
				if (master_nack) begin
					phase <= IGNORE; // wait for stop or start
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ev_i.scl_rise && bit_cnt < ACK_BIT) begin
			shreg <= {shreg[6:0], ev_i.sda_bit}; // msb first
		end
		if (rd_pend) begin
			rd_byte_o <= reg_o.rdata;
		end
	end

	assign phase_o = phase;
	assign bit_cnt_o = bit_cnt;

endmodule

// ==== verilog/bus_sampler.sv ====
`timescale 1ns/1ns

module bus_sampler import i2c_bus_pkg::*; (
	input logic sys_clk,
	input logic rst_n,
	input logic scl_i,
	input logic sda_i,
	bus_event_if.src ev_o
);

	logic [SYNC_STAGES-1:0] scl_sync; // bit 0 takes the pin
	logic [SYNC_STAGES-1:0] sda_sync;
	logic scl_s;
	logic sda_s;
	logic scl_q; // one-cycle history
	logic sda_q;

	assign scl_s = scl_sync[SYNC_STAGES-1];
	assign sda_s = sda_sync[SYNC_STAGES-1];

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scl_sync <= '1; // idle bus is high
			sda_sync <= '1;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end else begin
			scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl_i};
			sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_i};
			scl_q <= scl_s;
			sda_q <= sda_s;
		end
	end

	// events registered so they line up with the history level
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ev_o.scl_rise <= 1'b0;
			ev_o.scl_fall <= 1'b0;
			ev_o.start <= 1'b0;
			ev_o.stop <= 1'b0;
		end else begin
			ev_o.scl_rise <= scl_s && !scl_q;
			ev_o.scl_fall <= !scl_s && scl_q;
			ev_o.start <= !sda_s && sda_q && scl_s && scl_q; // sda falls, scl high
			ev_o.stop <= sda_s && !sda_q && scl_s && scl_q; // sda rises, scl high
		end
	end

	assign ev_o.sda_bit = sda_q;

endmodule

// ==== verilog/i2c_if.sv ====
`timescale 1ns/1ns

// bus conditions seen by the sampler, all in sys_clk domain
interface bus_event_if ();
	logic scl_rise; // one-cycle pulses
	logic scl_fall;
	logic start;
	logic stop;
	logic sda_bit; // level, synchronized sda

	modport src (
		output scl_rise,
		output scl_fall,
		output start,
		output stop,
		output sda_bit
	);

	modport dst (
		input scl_rise,
		input scl_fall,
		input start,
		input stop,
		input sda_bit
	);
endinterface

// register accesses from the transaction fsm
interface reg_access_if import slave_regs_pkg::*; ();
	logic wr_en; // strobes, never both high
	logic rd_en;
	reg_addr_t addr;
	reg_data_t wdata;
	reg_data_t rdata; // valid the cycle after rd_en
	dev_addr_t dev_addr;

	modport ctrl (
		output wr_en,
		output rd_en,
		output addr,
		output wdata,
		input rdata,
		input dev_addr
	);

	modport regs (
		input wr_en,
		input rd_en,
		input addr,
		input wdata,
		output rdata,
		output dev_addr
	);
endinterface

// ==== verilog/slave_regs_pkg.sv ====
package slave_regs_pkg;

	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [6:0] dev_addr_t;

	// register 0 mirrors the device address
	localparam reg_addr_t DEV_ADDR_REG = 16'h0000;

	// read-only id block
	localparam reg_addr_t ID_BASE = 16'h0001;
	localparam int ID_COUNT = 4;
	localparam reg_data_t ID_VALUES [ID_COUNT] = '{
		8'hA0,
		8'hA1,
		8'hA2,
		8'hA3
	};

	// read-write block
	localparam reg_addr_t RW_BASE = 16'h0005;
	localparam int RW_COUNT = 8;
	localparam reg_data_t RW_RESET_VALUES [RW_COUNT] = '{
		8'hB0, 8'hB1, 8'hB2, 8'hB3,
		8'hB4, 8'hB5, 8'hB6, 8'hB7
	};

	localparam reg_data_t UNMAPPED_DATA = 8'hFF; // anything outside the map

endpackage

// ==== verilog/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

	// input synchronizer depth, pins to usable level
	localparam int SYNC_STAGES = 2;

	// data bits per byte, the ninth bit is the acknowledge
	localparam int BITS_PER_BYTE = 8;

	typedef logic [3:0] bit_cnt_t; // 0..7 data, 8 ack

	// where the slave stands within a transaction
	typedef enum logic [2:0] {
		IDLE,
		DEV_ADDR,
		REG_ADDR_HI,
		REG_ADDR_LO,
		WRITE_DATA,
		READ_DATA,
		IGNORE
	} phase_t;

endpackage
